/* scarv_cop_pkg.sv */
// Shared widths, instruction encodings and field positions for the
// coprocessor load/store path
`default_nettype none

package scarv_cop_pkg;

    localparam int COP_WORD_W = 32;

    typedef logic [COP_WORD_W-1:0] cop_word_t;   // Data, address and instruction
    typedef logic [3:0]            cop_ben_t;    // One bit per byte lane
    typedef logic [3:0]            cpr_idx_t;
    typedef logic [2:0]            cop_class_t;
    typedef logic [3:0]            cop_subclass_t;

    // Instruction class
    localparam cop_class_t ICLASS_LOADSTORE = 3'd1;

    // Load/store subclasses
    localparam cop_subclass_t SCLASS_LW        = 4'h0;
    localparam cop_subclass_t SCLASS_LH        = 4'h1;
    localparam cop_subclass_t SCLASS_LB        = 4'h2;
    localparam cop_subclass_t SCLASS_SW        = 4'h3;
    localparam cop_subclass_t SCLASS_SH        = 4'h4;
    localparam cop_subclass_t SCLASS_SB        = 4'h5;
    localparam cop_subclass_t SCLASS_GATHER_B  = 4'h6;
    localparam cop_subclass_t SCLASS_GATHER_H  = 4'h7;
    localparam cop_subclass_t SCLASS_SCATTER_B = 4'h8;
    localparam cop_subclass_t SCLASS_SCATTER_H = 4'h9;

    // Instruction word field positions
    localparam int INSTR_SUBCLASS_HI = 31;
    localparam int INSTR_SUBCLASS_LO = 28;
    localparam int INSTR_CLASS_HI    = 27;
    localparam int INSTR_CLASS_LO    = 25;
    localparam int INSTR_CRD_HI      = 24;
    localparam int INSTR_CRD_LO      = 21;
    localparam int INSTR_CRS2_HI     = 20;
    localparam int INSTR_CRS2_LO     = 17;
    localparam int INSTR_CRS3_HI     = 16;
    localparam int INSTR_CRS3_LO     = 13;
    localparam int INSTR_WB_H_BIT    = 12;
    localparam int INSTR_WB_B_BIT    = 11;
    localparam int INSTR_IMM_HI      = 10;   // Sign bit of the immediate
    localparam int INSTR_IMM_LO      = 0;

    // Scatter/gather sequencer, one state per element still to come
    typedef enum logic [2:0] {
        FSM_IDLE,
        FSM_SG_H_1,
        FSM_SG_B_1,
        FSM_SG_B_2,
        FSM_SG_B_3
    } mem_fsm_e;

endpackage

`default_nettype wire

/* scarv_cop_decode.sv */
// Coprocessor instruction decoder, splits the word into the fields used
// by the register file and the memory unit
`timescale 1ns/1ps
`default_nettype none

module scarv_cop_decode (
    input  wire  scarv_cop_pkg::cop_word_t     instr_word,
    output scarv_cop_pkg::cop_class_t          id_class,
    output scarv_cop_pkg::cop_subclass_t       id_subclass,
    output scarv_cop_pkg::cpr_idx_t            id_crd,
    output scarv_cop_pkg::cpr_idx_t            id_crs2,
    output scarv_cop_pkg::cpr_idx_t            id_crs3,
    output logic                               id_wb_h,
    output logic                               id_wb_b,
    output scarv_cop_pkg::cop_word_t           id_imm
);
    import scarv_cop_pkg::*;

    localparam int IMM_W = INSTR_IMM_HI - INSTR_IMM_LO + 1;

    logic [IMM_W-1:0] imm_field;

    // Opcode fields
    assign id_class    = instr_word[INSTR_CLASS_HI:INSTR_CLASS_LO];
    assign id_subclass = instr_word[INSTR_SUBCLASS_HI:INSTR_SUBCLASS_LO];

    // Register indices
    assign id_crd  = instr_word[INSTR_CRD_HI:INSTR_CRD_LO];    // Load or gather destination
    assign id_crs2 = instr_word[INSTR_CRS2_HI:INSTR_CRS2_LO];  // Store data or offsets
    assign id_crs3 = instr_word[INSTR_CRS3_HI:INSTR_CRS3_LO];  // Scatter data

    // Lane selects for single halfword and byte accesses
    assign id_wb_h = instr_word[INSTR_WB_H_BIT];
    assign id_wb_b = instr_word[INSTR_WB_B_BIT];

    // Immediate offset, sign extended to a full word
    assign imm_field = instr_word[INSTR_IMM_HI:INSTR_IMM_LO];
    assign id_imm    = {{(COP_WORD_W - IMM_W){imm_field[IMM_W-1]}}, imm_field};

endmodule

`default_nettype wire

/* scarv_cop_cprs.sv */
// Coprocessor register file with two combinational read ports and one
// byte-enabled write port
`timescale 1ns/1ps
`default_nettype none

module scarv_cop_cprs #(
    parameter int CPR_COUNT = 16
) (
    input  wire                            g_clk,
    input  wire                            g_resetn,
    input  wire scarv_cop_pkg::cpr_idx_t   rs2_idx,
    input  wire scarv_cop_pkg::cpr_idx_t   rs3_idx,
    input  wire scarv_cop_pkg::cpr_idx_t   rd_idx,
    output scarv_cop_pkg::cop_word_t       rs2_data,
    output scarv_cop_pkg::cop_word_t       rs3_data,
    input  wire scarv_cop_pkg::cop_ben_t   wr_ben,
    input  wire scarv_cop_pkg::cop_word_t  wr_data
);
    import scarv_cop_pkg::*;

    cop_word_t regs [CPR_COUNT];

    // Indices beyond the implemented registers read as zero
    assign rs2_data = (int'(rs2_idx) < CPR_COUNT) ? regs[rs2_idx] : '0;
    assign rs3_data = (int'(rs3_idx) < CPR_COUNT) ? regs[rs3_idx] : '0;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < CPR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CPR_COUNT; i++) begin
                if (cpr_idx_t'(i) == rd_idx) begin
                    // Only the enabled lanes change
                    for (int b = 0; b < 4; b++) begin
                        if (wr_ben[b]) begin
                            regs[i][8*b +: 8] <= wr_data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* scarv_cop_mem.sv */
// Coprocessor memory unit, runs single loads and stores and byte or
// halfword scatter/gather sequences on a word-addressed bus
`timescale 1ns/1ps
`default_nettype none

module scarv_cop_mem (
    input  wire                                g_clk,
    input  wire                                g_resetn,
    input  wire                                mem_ivalid,      // Held until mem_idone
    output logic                               mem_idone,
    output logic                               mem_addr_error,
    output logic                               mem_bus_error,
    output logic                               mem_is_store,
    input  wire scarv_cop_pkg::cop_word_t      gpr_rs1,         // Base address
    input  wire scarv_cop_pkg::cop_word_t      cpr_rs2,
    input  wire scarv_cop_pkg::cop_word_t      cpr_rs3,
    input  wire                                id_wb_h,
    input  wire                                id_wb_b,
    input  wire scarv_cop_pkg::cop_word_t      id_imm,
    input  wire scarv_cop_pkg::cop_class_t     id_class,
    input  wire scarv_cop_pkg::cop_subclass_t  id_subclass,
    output scarv_cop_pkg::cop_ben_t            cpr_wr_ben,
    output scarv_cop_pkg::cop_word_t           cpr_wr_data,
    output logic                               mem_cen,
    output logic                               mem_wen,
    output scarv_cop_pkg::cop_word_t           mem_addr,
    output scarv_cop_pkg::cop_word_t           mem_wdata,
    output scarv_cop_pkg::cop_ben_t            mem_ben,
    input  wire scarv_cop_pkg::cop_word_t      mem_rdata,
    input  wire                                mem_stall,
    input  wire                                mem_error
);
    import scarv_cop_pkg::*;

    // Element number that a sequencer state stands for
    function automatic logic [1:0] elem_of(input mem_fsm_e s);
        case (s)
            FSM_SG_H_1, FSM_SG_B_1: elem_of = 2'd1;
            FSM_SG_B_2:             elem_of = 2'd2;
            FSM_SG_B_3:             elem_of = 2'd3;
            default:                elem_of = 2'd0;
        endcase
    endfunction

    mem_fsm_e   mem_fsm;
    mem_fsm_e   n_mem_fsm;
    logic       p_cen;          // A request is waiting for its response
    logic [1:0] p_addr_lsbs;    // Byte offset of that request
    cop_ben_t   ben_sel;
    cop_ben_t   wb_ben;

    // Instruction decode
    wire is_mem  = mem_ivalid && (id_class == ICLASS_LOADSTORE);
    wire is_lw   = is_mem && (id_subclass == SCLASS_LW);
    wire is_lh   = is_mem && (id_subclass == SCLASS_LH);
    wire is_lb   = is_mem && (id_subclass == SCLASS_LB);
    wire is_sw   = is_mem && (id_subclass == SCLASS_SW);
    wire is_sh   = is_mem && (id_subclass == SCLASS_SH);
    wire is_sb   = is_mem && (id_subclass == SCLASS_SB);
    wire is_ga_b = is_mem && (id_subclass == SCLASS_GATHER_B);
    wire is_ga_h = is_mem && (id_subclass == SCLASS_GATHER_H);
    wire is_sc_b = is_mem && (id_subclass == SCLASS_SCATTER_B);
    wire is_sc_h = is_mem && (id_subclass == SCLASS_SCATTER_H);

    wire single_mem = is_lw || is_lh || is_lb || is_sw || is_sh || is_sb;
    wire is_sg_h    = is_ga_h || is_sc_h;
    wire is_sg_b    = is_ga_b || is_sc_b;
    wire word_op    = is_lw || is_sw;
    wire half_op    = is_lh || is_sh || is_sg_h;
    wire store_op   = is_sw || is_sh || is_sb || is_sc_h || is_sc_b;

    // Element being requested and element being answered
    wire [1:0] req_elem = elem_of(n_mem_fsm);
    wire [1:0] rsp_elem = elem_of(mem_fsm);

    // Address forming, offsets from lanes of crs2 for scatter/gather
    wire [15:0] sg_offset = is_sg_h ? cpr_rs2[{req_elem[0], 4'b0000} +: 16] :
                                      {8'h00, cpr_rs2[{req_elem, 3'b000} +: 8]};
    wire cop_word_t addr_offset = single_mem ? id_imm : {16'h0000, sg_offset};
    wire cop_word_t mem_address = gpr_rs1 + addr_offset;

    // Alignment checked on the sum inputs, so the FSM never waits on the adder
    wire [1:0] lsb_sum      = gpr_rs1[1:0] + id_imm[1:0];
    wire       sgh_addr_err = (gpr_rs1[0] ^ cpr_rs2[0]) || (gpr_rs1[0] ^ cpr_rs2[16]);

    assign mem_addr_error = (is_lw || is_sw) && (lsb_sum != 2'b00) ||
                            (is_lh || is_sh) && lsb_sum[0]         ||
                            is_sg_h && sgh_addr_err;

    // Response tracking
    wire rsp_valid = p_cen && !mem_stall;
    wire txn_good  = rsp_valid && !mem_error && !mem_addr_error;
    wire txn_error = mem_bus_error || mem_addr_error;

    assign mem_bus_error = rsp_valid && mem_error;
    assign mem_idone     = (txn_good && (n_mem_fsm == FSM_IDLE)) || txn_error;
    assign mem_is_store  = store_op;

    // Bus request, held by the FSM while the bus stalls
    assign mem_cen  = (single_mem || is_sg_h || is_sg_b) && !mem_idone && !mem_addr_error;
    assign mem_wen  = mem_cen && store_op;
    assign mem_addr = {mem_address[31:2], 2'b00};

    always_comb begin
        if (word_op) begin
            ben_sel = 4'b1111;
        end else if (half_op) begin
            ben_sel = mem_address[1] ? 4'b1100 : 4'b0011;
        end else begin
            ben_sel = 4'b0001 << mem_address[1:0];
        end
    end

    assign mem_ben = mem_cen ? ben_sel : 4'b0000;

    // Store data, scatters take element i from lane i of crs3
    wire [15:0] st_half = is_sc_h ? cpr_rs3[{req_elem[0], 4'b0000} +: 16] :
                                    cpr_rs2[{id_wb_h, 4'b0000} +: 16];
    wire [7:0]  st_byte = is_sc_b ? cpr_rs3[{req_elem, 3'b000} +: 8] :
                                    cpr_rs2[{id_wb_h, id_wb_b, 3'b000} +: 8];

    assign mem_wdata = word_op ? cpr_rs2 :
                       half_op ? {16'h0000, st_half} << {mem_address[1], 4'b0000} :
                                 {24'h000000, st_byte} << {mem_address[1:0], 3'b000};

    // Returned data, steered by the lane of the answered request
    wire        load_half = is_lh || is_ga_h;
    wire        load_byte = is_lb || is_ga_b;
    wire [15:0] rsp_half  = mem_rdata[{p_addr_lsbs[1], 4'b0000} +: 16];
    wire [7:0]  rsp_byte  = mem_rdata[{p_addr_lsbs, 3'b000} +: 8];
    wire        half_lane = is_ga_h ? rsp_elem[0] : id_wb_h;   // Gather element i to lane i
    wire [1:0]  byte_lane = is_ga_b ? rsp_elem : {id_wb_h, id_wb_b};

    always_comb begin
        if (is_lw) begin
            wb_ben = 4'b1111;
        end else if (load_half) begin
            wb_ben = half_lane ? 4'b1100 : 4'b0011;
        end else if (load_byte) begin
            wb_ben = 4'b0001 << byte_lane;
        end else begin
            wb_ben = 4'b0000;     // Stores write nothing back
        end
    end

    assign cpr_wr_ben  = txn_good ? wb_ben : 4'b0000;
    assign cpr_wr_data = load_half ? {2{rsp_half}} :
                         load_byte ? {4{rsp_byte}} :
                                     mem_rdata;

    // Sequencer, one step per good response
    always_comb begin
        case (mem_fsm)
            FSM_IDLE: begin
                if (txn_good && is_sg_b) begin
                    n_mem_fsm = FSM_SG_B_1;
                end else if (txn_good && is_sg_h) begin
                    n_mem_fsm = FSM_SG_H_1;
                end else begin
                    n_mem_fsm = FSM_IDLE;
                end
            end
            FSM_SG_H_1: n_mem_fsm = (txn_good || txn_error) ? FSM_IDLE : FSM_SG_H_1;
            FSM_SG_B_1: n_mem_fsm = txn_good  ? FSM_SG_B_2 :
                                    txn_error ? FSM_IDLE   : FSM_SG_B_1;
            FSM_SG_B_2: n_mem_fsm = txn_good  ? FSM_SG_B_3 :
                                    txn_error ? FSM_IDLE   : FSM_SG_B_2;
            FSM_SG_B_3: n_mem_fsm = (txn_good || txn_error) ? FSM_IDLE : FSM_SG_B_3;
            default:    n_mem_fsm = FSM_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mem_fsm <= FSM_IDLE;
            p_cen   <= 1'b0;
        end else begin
            mem_fsm <= n_mem_fsm;
            p_cen   <= mem_cen || (p_cen && mem_stall);   // Stays set across stalls
        end
    end

    always_ff @(posedge g_clk) begin
        p_addr_lsbs <= mem_address[1:0];
    end

endmodule

`default_nettype wire

/* scarv_cop_lsu_top.sv */
// Coprocessor load/store path, decoder and register file feeding the
// memory unit between the host and the memory bus
`timescale 1ns/1ps
`default_nettype none

module scarv_cop_lsu_top #(
    parameter int CPR_COUNT = 16
) (
    input  wire                            g_clk,
    input  wire                            g_resetn,
    input  wire                            instr_valid,
    input  wire scarv_cop_pkg::cop_word_t  instr_word,
    input  wire scarv_cop_pkg::cop_word_t  gpr_rs1,
    output wire                            instr_done,
    output wire                            addr_error,
    output wire                            bus_error,
    output wire                            is_store,
    output wire                            mem_cen,
    output wire                            mem_wen,
    output wire scarv_cop_pkg::cop_word_t  mem_addr,
    output wire scarv_cop_pkg::cop_word_t  mem_wdata,
    output wire scarv_cop_pkg::cop_ben_t   mem_ben,
    input  wire scarv_cop_pkg::cop_word_t  mem_rdata,
    input  wire                            mem_stall,
    input  wire                            mem_error
);
    import scarv_cop_pkg::*;

    // Decoded fields
    wire cop_class_t    id_class;
    wire cop_subclass_t id_subclass;
    wire cpr_idx_t      id_crd;
    wire cpr_idx_t      id_crs2;
    wire cpr_idx_t      id_crs3;
    wire                id_wb_h;
    wire                id_wb_b;
    wire cop_word_t     id_imm;

    // Register file traffic
    wire cop_word_t     cpr_rs2;
    wire cop_word_t     cpr_rs3;
    wire cop_ben_t      cpr_wr_ben;
    wire cop_word_t     cpr_wr_data;

    scarv_cop_decode decode0 (
        .instr_word  (instr_word),
        .id_class    (id_class),
        .id_subclass (id_subclass),
        .id_crd      (id_crd),
        .id_crs2     (id_crs2),
        .id_crs3     (id_crs3),
        .id_wb_h     (id_wb_h),
        .id_wb_b     (id_wb_b),
        .id_imm      (id_imm)
    );

    scarv_cop_cprs #(
        .CPR_COUNT (CPR_COUNT)
    ) cprs0 (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .rs2_idx  (id_crs2),
        .rs3_idx  (id_crs3),
        .rd_idx   (id_crd),
        .rs2_data (cpr_rs2),
        .rs3_data (cpr_rs3),
        .wr_ben   (cpr_wr_ben),
        .wr_data  (cpr_wr_data)
    );

    scarv_cop_mem mem0 (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .mem_ivalid     (instr_valid),
        .mem_idone      (instr_done),
        .mem_addr_error (addr_error),
        .mem_bus_error  (bus_error),
        .mem_is_store   (is_store),
        .gpr_rs1        (gpr_rs1),
        .cpr_rs2        (cpr_rs2),
        .cpr_rs3        (cpr_rs3),
        .id_wb_h        (id_wb_h),
        .id_wb_b        (id_wb_b),
        .id_imm         (id_imm),
        .id_class       (id_class),
        .id_subclass    (id_subclass),
        .cpr_wr_ben     (cpr_wr_ben),
        .cpr_wr_data    (cpr_wr_data),
        .mem_cen        (mem_cen),
        .mem_wen        (mem_wen),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_ben        (mem_ben),
        .mem_rdata      (mem_rdata),
        .mem_stall      (mem_stall),
        .mem_error      (mem_error)
    );

endmodule

`default_nettype wire

/* tb_scarv_cop_mem_model.sv */
// Testbench memory, 256 words with a one-cycle response, random stall
// and an error window at word addresses 0xF0 to 0xFF
`timescale 1ns/1ps
`default_nettype none

module tb_scarv_cop_mem_model (
    input  wire                            g_clk,
    input  wire                            g_resetn,
    input  wire                            stall_en,
    input  wire                            mem_cen,
    input  wire                            mem_wen,
    input  wire scarv_cop_pkg::cop_word_t  mem_addr,
    input  wire scarv_cop_pkg::cop_word_t  mem_wdata,
    input  wire scarv_cop_pkg::cop_ben_t   mem_ben,
    output scarv_cop_pkg::cop_word_t       mem_rdata,
    output logic                           mem_stall,
    output logic                           mem_error
);
    import scarv_cop_pkg::*;

    cop_word_t mem [256];
    integer    seed = 32'ha38a;
    logic      pending;        // Accepted request whose response is not taken yet
    logic      pending_n;
    logic      waiting;
    logic      in_window;
    logic [7:0] idx;

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            pending   <= 1'b0;
            mem_stall <= 1'b0;
            mem_error <= 1'b0;
            mem_rdata <= '0;
        end else begin
            waiting   = pending && mem_stall;   // Response still held back
            pending_n = waiting;
            if (mem_cen && !waiting) begin
                idx       = mem_addr[9:2];
                in_window = (idx >= 8'hf0);
                if (mem_wen && !in_window) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_ben[b]) begin
                            mem[idx][8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                end
                mem_rdata <= mem[idx];
                mem_error <= in_window;
                pending_n = 1'b1;
            end
            pending   <= pending_n;
            mem_stall <= pending_n && stall_en && (($random(seed) & 3) == 0);
        end
    end

endmodule

`default_nettype wire

/* tb_scarv_cop_lsu_properties.sv */
// Bus and completion properties of the load/store top level
`timescale 1ns/1ps
`default_nettype none

module tb_scarv_cop_lsu_properties (
    input wire                            g_clk,
    input wire                            g_resetn,
    input wire                            instr_valid,
    input wire                            mem_cen,
    input wire scarv_cop_pkg::cop_word_t  mem_addr,
    input wire                            addr_error,
    input wire                            bus_error,
    input wire                            mem_stall
);
    int fail_count = 0;

    a_addr_aligned: assert property (@(posedge g_clk) disable iff (!g_resetn)
        mem_cen |-> (mem_addr[1:0] == 2'b00))
        else begin
            $error("mem_addr not word aligned");
            fail_count++;
        end

    a_addr_err_no_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        addr_error |-> !mem_cen)
        else begin
            $error("addr_error together with mem_cen");
            fail_count++;
        end

    a_bus_err_no_stall: assert property (@(posedge g_clk) disable iff (!g_resetn)
        bus_error |-> !mem_stall)
        else begin
            $error("bus_error during mem_stall");
            fail_count++;
        end

    a_idle_no_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !instr_valid |-> !mem_cen)
        else begin
            $error("mem_cen without instr_valid");
            fail_count++;
        end

endmodule

bind scarv_cop_lsu_top tb_scarv_cop_lsu_properties props0 (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .instr_valid (instr_valid),
    .mem_cen     (mem_cen),
    .mem_addr    (mem_addr),
    .addr_error  (addr_error),
    .bus_error   (bus_error),
    .mem_stall   (mem_stall)
);

`default_nettype wire

/* tb_scarv_cop_lsu.sv */
// Testbench for the coprocessor load/store path, table driven against
// a mirror of memory and registers, run without and with bus stalls
`timescale 1ns/1ps
`default_nettype none

module tb_scarv_cop_lsu;
    import scarv_cop_pkg::*;

    localparam int K_OK = 0;
    localparam int K_AE = 1;
    localparam int K_BE = 2;

    logic g_clk, g_resetn, instr_valid, stall_en;
    cop_word_t instr_word, gpr_rs1;
    wire instr_done, addr_error, bus_error, is_store, mem_cen, mem_wen, mem_stall, mem_error;
    wire cop_word_t mem_addr, mem_wdata, mem_rdata;
    wire cop_ben_t  mem_ben;

    string     row_name [$];
    cop_word_t row_instr [$];
    cop_word_t row_rs1 [$];
    int        row_kind [$];
    cop_word_t mirror_mem [256];
    cop_word_t cpr_m [16];
    int        err_count = 0;
    int        test_count = 0;
    int        stall_cycles = 0;
    logic      timed_out = 1'b0;

    scarv_cop_lsu_top #(.CPR_COUNT(16)) dut0 (
        .g_clk(g_clk), .g_resetn(g_resetn), .instr_valid(instr_valid),
        .instr_word(instr_word), .gpr_rs1(gpr_rs1), .instr_done(instr_done),
        .addr_error(addr_error), .bus_error(bus_error), .is_store(is_store),
        .mem_cen(mem_cen), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ben(mem_ben), .mem_rdata(mem_rdata), .mem_stall(mem_stall), .mem_error(mem_error)
    );

    tb_scarv_cop_mem_model mem_model0 (
        .g_clk(g_clk), .g_resetn(g_resetn), .stall_en(stall_en), .mem_cen(mem_cen),
        .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ben(mem_ben),
        .mem_rdata(mem_rdata), .mem_stall(mem_stall), .mem_error(mem_error)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    function automatic cop_word_t encode(input cop_subclass_t sub, input int crd, input int crs2,
                                         input int crs3, input logic [1:0] wb, input int imm);
        encode = {sub, ICLASS_LOADSTORE, crd[3:0], crs2[3:0], crs3[3:0], wb, imm[10:0]};
    endfunction

    task automatic add_row(input string n, input cop_word_t iw, input cop_word_t rs1, input int k);
        row_name.push_back(n);
        row_instr.push_back(iw);
        row_rs1.push_back(rs1);
        row_kind.push_back(k);
    endtask

    task automatic check_word(input string n, input cop_word_t exp, input cop_word_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", n, exp, act);
            err_count++;
        end
    endtask

    task automatic check_ben(input string n, input cop_ben_t exp, input cop_ben_t act);
        if (exp !== act) begin
            $display("** Error %s: mem_ben expected %b, actual %b", n, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string n, input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: %s expected %b, actual %b", n, what, exp, act);
            err_count++;
        end
    endtask

    // Expected effect of one instruction on the mirror, by the lane and address rules
    task automatic apply_rules(input cop_word_t iw, input cop_word_t rs1, output cop_ben_t ben0);
        cop_subclass_t sub;
        int crd, size, n, idx;
        logic [1:0] wb;
        logic sg, bad, stop, store;
        cop_word_t imm, r2, r3, a, w;
        cop_word_t off [4];
        sub   = iw[31:28];
        crd   = iw[24:21];
        wb    = iw[12:11];
        imm   = {{21{iw[10]}}, iw[10:0]};
        r2    = cpr_m[iw[20:17]];
        r3    = cpr_m[iw[16:13]];
        sg    = (sub >= SCLASS_GATHER_B);
        store = sub inside {SCLASS_SW, SCLASS_SH, SCLASS_SB, SCLASS_SCATTER_B, SCLASS_SCATTER_H};
        size  = (sub inside {SCLASS_LW, SCLASS_SW}) ? 4 :
                (sub inside {SCLASS_LH, SCLASS_SH, SCLASS_GATHER_H, SCLASS_SCATTER_H}) ? 2 : 1;
        n     = !sg ? 1 : (size == 2) ? 2 : 4;
        bad   = 1'b0;
        for (int i = 0; i < n; i++) begin
            off[i] = !sg ? imm : (size == 2) ? {16'h0, r2[16*i +: 16]} : {24'h0, r2[8*i +: 8]};
            a = rs1 + off[i];
            if ((size == 4 && a[1:0] != 2'b00) || (size == 2 && a[0])) bad = 1'b1;
        end
        a    = rs1 + off[0];
        ben0 = (size == 4) ? 4'hf : (size == 2) ? (a[1] ? 4'hc : 4'h3) : 4'h1 << a[1:0];
        stop = bad;
        for (int i = 0; i < n; i++) begin
            a   = rs1 + off[i];
            idx = a[9:2];
            if (idx >= 240) stop = 1'b1;        // Faulting element and the rest are dropped
            if (!stop && store) begin
                if (size == 4) mirror_mem[idx] = r2;
                else if (size == 2)
                    mirror_mem[idx][16*a[1] +: 16] = sg ? r3[16*i +: 16] : r2[16*wb[1] +: 16];
                else
                    mirror_mem[idx][8*a[1:0] +: 8] = sg ? r3[8*i +: 8] : r2[8*wb +: 8];
            end else if (!stop) begin
                w = mirror_mem[idx];
                if (size == 4) cpr_m[crd] = w;
                else if (size == 2) cpr_m[crd][16*(sg ? i : wb[1]) +: 16] = w[16*a[1] +: 16];
                else cpr_m[crd][8*(sg ? i : wb) +: 8] = w[8*a[1:0] +: 8];
            end
        end
    endtask

    task automatic preload;
        cop_word_t v;
        for (int i = 0; i < 256; i++) begin
            v = {~i[7:0], i[7:0] ^ 8'h3c, i[7:0] + 8'h51, i[7:0]};
            if (i == 8)  v = 32'h1f120904;     // Byte scatter offsets
            if (i == 9)  v = 32'h00260010;     // Halfword gather offsets
            if (i == 10) v = 32'h00200013;     // Odd halfword offset
            if (i == 11) v = 32'h283b2631;     // Byte gather offsets
            if (i == 12) v = 32'h08280400;     // Element 2 hits the error window
            mem_model0.mem[i] = v;
            mirror_mem[i] = v;
        end
        for (int r = 0; r < 16; r++) cpr_m[r] = '0;
    endtask

    task automatic run_row(input int t);
        int cycles;
        logic cen_seen, done_seen, got_ae, got_be, got_st;
        cop_ben_t ben0, first_ben;
        int errs_before;
        errs_before = err_count;
        cycles = 0;
        cen_seen = 1'b0;
        done_seen = 1'b0;
        first_ben = '0;
        apply_rules(row_instr[t], row_rs1[t], ben0);
        @(posedge g_clk);
        #1;
        instr_valid = 1'b1;
        instr_word  = row_instr[t];
        gpr_rs1     = row_rs1[t];
        while (!done_seen && !timed_out) begin
            @(negedge g_clk);
            if (mem_stall) stall_cycles++;
            if (mem_cen && !cen_seen) begin
                cen_seen  = 1'b1;
                first_ben = mem_ben;
            end
            if (instr_done) begin
                done_seen = 1'b1;
                {got_ae, got_be, got_st} = {addr_error, bus_error, is_store};
            end else begin
                cycles++;
                if (cycles > 50) begin
                    $display("Timeout: instr_done never came in test %s", row_name[t]);
                    timed_out = 1'b1;
                    err_count++;
                end
            end
        end
        @(posedge g_clk);
        #1;
        instr_valid = 1'b0;
        if (done_seen) begin
            check_flag(row_name[t], "addr_error", row_kind[t] == K_AE, got_ae);
            check_flag(row_name[t], "bus_error", row_kind[t] == K_BE, got_be);
            check_flag(row_name[t], "is_store", row_instr[t][31:28] inside
                {SCLASS_SW, SCLASS_SH, SCLASS_SB, SCLASS_SCATTER_B, SCLASS_SCATTER_H}, got_st);
            check_flag(row_name[t], "bus request", row_kind[t] != K_AE, cen_seen);
            if (row_kind[t] != K_AE) check_ben(row_name[t], ben0, first_ben);
            for (int i = 0; i < 256; i++) check_word(row_name[t], mirror_mem[i], mem_model0.mem[i]);
        end
        test_count++;
        $display("%s %s", (err_count == errs_before) ? "ok  " : "bad ", row_name[t]);
    endtask

    initial begin
        g_resetn = 1'b0;
        instr_valid = 1'b0;
        instr_word = '0;
        gpr_rs1 = '0;
        stall_en = 1'b0;
        add_row("lw_offs_b",  encode(SCLASS_LW, 1, 0, 0, 2'd0, 'h20), 0, K_OK);
        add_row("lw_offs_h",  encode(SCLASS_LW, 2, 0, 0, 2'd0, 'h24), 0, K_OK);
        add_row("lw_offs_odd", encode(SCLASS_LW, 3, 0, 0, 2'd0, 'h28), 0, K_OK);
        add_row("lw_offs_g",  encode(SCLASS_LW, 4, 0, 0, 2'd0, 'h2c), 0, K_OK);
        add_row("lw_offs_e",  encode(SCLASS_LW, 5, 0, 0, 2'd0, 'h30), 0, K_OK);
        add_row("lw_data",    encode(SCLASS_LW, 6, 0, 0, 2'd0, 'h50), 0, K_OK);
        add_row("lw_keep_a",  encode(SCLASS_LW, 11, 0, 0, 2'd0, 'h54), 0, K_OK);
        add_row("lw_keep_b",  encode(SCLASS_LW, 12, 0, 0, 2'd0, 'h58), 0, K_OK);
        add_row("sw_round",   encode(SCLASS_SW, 0, 6, 0, 2'd0, 'h60), 0, K_OK);
        add_row("lh_lo",      encode(SCLASS_LH, 7, 0, 0, 2'd0, 'h52), 0, K_OK);
        add_row("lh_hi",      encode(SCLASS_LH, 7, 0, 0, 2'd2, 'h44), 0, K_OK);
        add_row("lb_0",       encode(SCLASS_LB, 8, 0, 0, 2'd0, 'h45), 0, K_OK);
        add_row("lb_1",       encode(SCLASS_LB, 8, 0, 0, 2'd1, 'h4a), 0, K_OK);
        add_row("lb_2",       encode(SCLASS_LB, 8, 0, 0, 2'd2, 'h47), 0, K_OK);
        add_row("lb_3",       encode(SCLASS_LB, 8, 0, 0, 2'd3, 'h48), 0, K_OK);
        add_row("sw_half",    encode(SCLASS_SW, 0, 7, 0, 2'd0, 'h64), 0, K_OK);
        add_row("sw_byte",    encode(SCLASS_SW, 0, 8, 0, 2'd0, 'h68), 0, K_OK);
        add_row("sh_part",    encode(SCLASS_SH, 0, 6, 0, 2'd2, 'h6e), 0, K_OK);
        add_row("sb_part",    encode(SCLASS_SB, 0, 6, 0, 2'd1, 'h71), 0, K_OK);
        add_row("scatter_b",  encode(SCLASS_SCATTER_B, 0, 1, 6, 2'd0, 0), 'h100, K_OK);
        add_row("gather_h",   encode(SCLASS_GATHER_H, 9, 2, 0, 2'd0, 0), 'h180, K_OK);
        add_row("sw_gath_h",  encode(SCLASS_SW, 0, 9, 0, 2'd0, 'h74), 0, K_OK);
        add_row("gather_b",   encode(SCLASS_GATHER_B, 10, 4, 0, 2'd0, 0), 'h200, K_OK);
        add_row("sw_gath_b",  encode(SCLASS_SW, 0, 10, 0, 2'd0, 'h78), 0, K_OK);
        add_row("scatter_h",  encode(SCLASS_SCATTER_H, 0, 2, 8, 2'd0, 0), 'h140, K_OK);
        add_row("ae_lw",      encode(SCLASS_LW, 11, 0, 0, 2'd0, 'h22), 0, K_AE);
        add_row("ae_sw",      encode(SCLASS_SW, 0, 6, 0, 2'd0, 1), 'h80, K_AE);
        add_row("ae_lh",      encode(SCLASS_LH, 11, 0, 0, 2'd0, 'h43), 0, K_AE);
        add_row("ae_sh",      encode(SCLASS_SH, 0, 6, 0, 2'd0, 'h41), 0, K_AE);
        add_row("ae_scat_h",  encode(SCLASS_SCATTER_H, 0, 3, 6, 2'd0, 0), 'h140, K_AE);
        add_row("ae_gath_h",  encode(SCLASS_GATHER_H, 11, 3, 0, 2'd0, 0), 'h140, K_AE);
        add_row("sw_keep_a",  encode(SCLASS_SW, 0, 11, 0, 2'd0, 'h7c), 0, K_OK);
        add_row("be_lw",      encode(SCLASS_LW, 12, 0, 0, 2'd0, 0), 'h3c0, K_BE);
        add_row("sw_keep_b",  encode(SCLASS_SW, 0, 12, 0, 2'd0, 'h84), 0, K_OK);
        add_row("be_gath_b",  encode(SCLASS_GATHER_B, 12, 5, 0, 2'd0, 0), 'h3a0, K_BE);
        add_row("sw_part_b",  encode(SCLASS_SW, 0, 12, 0, 2'd0, 'h88), 0, K_OK);
        add_row("be_sw",      encode(SCLASS_SW, 0, 6, 0, 2'd0, 0), 'h3f0, K_BE);
        add_row("be_scat_b",  encode(SCLASS_SCATTER_B, 0, 5, 6, 2'd0, 0), 'h3a0, K_BE);
        add_row("lw_neg",     encode(SCLASS_LW, 13, 0, 0, 2'd0, -4), 'h100, K_OK);
        add_row("sw_neg",     encode(SCLASS_SW, 0, 13, 0, 2'd0, 'h8c), 0, K_OK);
        // Second pass repeats the table under random stalls
        for (int pass = 0; pass < 2 && !timed_out; pass++) begin
            g_resetn = 1'b0;
            stall_en = pass[0];
            stall_cycles = 0;
            repeat (8) @(posedge g_clk);
            #1;
            g_resetn = 1'b1;
            preload();
            for (int t = 0; t < row_name.size() && !timed_out; t++) run_row(t);
            if (stall_en && !timed_out && stall_cycles == 0) begin
                $display("No bus stall happened in the stalled pass");
                err_count++;
            end
        end
        if (dut0.props0.fail_count != 0) begin
            $display("Bus assertions failed %0d times", dut0.props0.fail_count);
            err_count++;
        end
        $display("Tests run: %0d, errors: %0d", test_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
scarv_cop_pkg.sv
scarv_cop_decode.sv
scarv_cop_cprs.sv
scarv_cop_mem.sv
scarv_cop_lsu_top.sv
tb_scarv_cop_mem_model.sv
tb_scarv_cop_lsu_properties.sv
tb_scarv_cop_lsu.sv
